// ==== sched_consts.svh ====
`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

// address fields, request address is {row, bank, col}
`define SCHED_ROW_W     8
`define SCHED_COL_W     4
`define SCHED_BANK_W    2
`define SCHED_ADDR_W    14

`define SCHED_NUM_BANKS 4   // flat bank index, no bank groups

`define SCHED_DATA_W    32  // write data path

// entries per read or write queue of one bank
`define SCHED_Q_DEPTH   4

// bank recovery, in cycles with want held low
`define SCHED_ACT_LAT   4   // after activate
`define SCHED_PRE_LAT   3   // after precharge

`endif

// ==== sched_pkg.sv ====
`include "sched_consts.svh"

package sched_pkg;

    // command kinds as seen on the cmd output
    typedef enum logic [1:0] {
        CMD_RD  = 2'd0,
        CMD_WR  = 2'd1,
        CMD_ACT = 2'd2,
        CMD_PRE = 2'd3
    } dram_cmd_t;

    // queued read, bank is implied by the queue it sits in
    typedef struct packed {
        logic [`SCHED_ROW_W-1:0] row;
        logic [`SCHED_COL_W-1:0] col;
    } rd_req_t;

    // queued write with its payload
    typedef struct packed {
        logic [`SCHED_ROW_W-1:0]  row;
        logic [`SCHED_COL_W-1:0]  col;
        logic [`SCHED_DATA_W-1:0] data;
    } wr_req_t;

endpackage

// ==== req_fifo.sv ====
`include "sched_consts.svh"

module req_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);

    localparam int DEPTH = `SCHED_Q_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign empty = (count == '0);
    assign dout  = mem[rd_ptr]; // head entry, valid while not empty

    assign do_pop  = pop && !empty;
    // a full queue still takes a push when it pops in the same cycle
    assign do_push = push && ((count != CNT_W'(DEPTH)) || do_pop);

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push+pop together
            endcase
        end
    end

endmodule

// ==== req_router.sv ====
`include "sched_consts.svh"

module req_router import sched_pkg::*; (
    input  logic                        clk_in,
    input  logic                        rst_in,
    input  logic                        req_valid,
    input  logic                        req_write,
    input  logic [`SCHED_ADDR_W-1:0]    req_addr,
    input  logic [`SCHED_DATA_W-1:0]    req_data,
    output logic [`SCHED_NUM_BANKS-1:0] push_rd,
    output logic [`SCHED_NUM_BANKS-1:0] push_wr,
    output rd_req_t                     rd_req,
    output wr_req_t                     wr_req
);

    // field offsets inside the request address
    localparam int BANK_LSB = `SCHED_COL_W;
    localparam int ROW_LSB  = `SCHED_COL_W + `SCHED_BANK_W;

    logic                       valid_q;
    logic                       write_q;
    logic [`SCHED_ROW_W-1:0]    row_q;
    logic [`SCHED_BANK_W-1:0]   bank_q;
    logic [`SCHED_COL_W-1:0]    col_q;
    logic [`SCHED_DATA_W-1:0]   data_q;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    // request fields, only meaningful while valid_q is set
    always_ff @(posedge clk_in) begin
        if (req_valid) begin
            write_q <= req_write;
            row_q   <= req_addr[ROW_LSB +: `SCHED_ROW_W];
            bank_q  <= req_addr[BANK_LSB +: `SCHED_BANK_W];
            col_q   <= req_addr[0 +: `SCHED_COL_W];
            data_q  <= req_data;
        end
    end

    // one push bit per cycle, to the decoded bank
    always_comb begin
        for (int b = 0; b < `SCHED_NUM_BANKS; b++) begin
            push_rd[b] = valid_q && !write_q && (bank_q == `SCHED_BANK_W'(b));
            push_wr[b] = valid_q &&  write_q && (bank_q == `SCHED_BANK_W'(b));
        end
    end

    // payload is shared by all banks, the push bits pick the queue
    assign rd_req.row  = row_q;
    assign rd_req.col  = col_q;
    assign wr_req.row  = row_q;
    assign wr_req.col  = col_q;
    assign wr_req.data = data_q;

endmodule

// ==== bank_ctrl.sv ====
`include "sched_consts.svh"

module bank_ctrl import sched_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     push_rd,
    input  logic                     push_wr,
    input  rd_req_t                  rd_req,
    input  wr_req_t                  wr_req,
    input  logic                     grant,
    output logic                     want,
    output dram_cmd_t                want_cmd,
    output logic [`SCHED_ROW_W-1:0]  want_row,
    output logic [`SCHED_COL_W-1:0]  want_col,
    output logic [`SCHED_DATA_W-1:0] want_data
);

    localparam int MAX_LAT = (`SCHED_ACT_LAT > `SCHED_PRE_LAT) ? `SCHED_ACT_LAT
                                                              : `SCHED_PRE_LAT;
    localparam int TMR_W   = $clog2(MAX_LAT + 1);

    rd_req_t                  rd_head;
    wr_req_t                  wr_head;
    logic                     rd_empty;
    logic                     wr_empty;
    logic                     rd_pop;
    logic                     wr_pop;

    logic                     is_open;
    logic [`SCHED_ROW_W-1:0]  open_row;
    logic [TMR_W-1:0]         timer;

    logic                     head_valid;
    logic                     head_is_rd;
    logic [`SCHED_ROW_W-1:0]  head_row;
    logic                     row_hit;

    req_fifo #(.payload_t(rd_req_t)) rd_q (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .push   (push_rd),
        .din    (rd_req),
        .pop    (rd_pop),
        .dout   (rd_head),
        .empty  (rd_empty)
    );

    req_fifo #(.payload_t(wr_req_t)) wr_q (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .push   (push_wr),
        .din    (wr_req),
        .pop    (wr_pop),
        .dout   (wr_head),
        .empty  (wr_empty)
    );

    // reads win over writes whenever the read queue holds something
    assign head_is_rd = !rd_empty;
    assign head_valid = !rd_empty || !wr_empty;
    assign head_row   = head_is_rd ? rd_head.row : wr_head.row;
    assign row_hit    = is_open && (open_row == head_row);

    always_comb begin
        want      = (timer == '0) && head_valid;   // blocked while recovering
        want_row  = head_row;
        want_col  = head_is_rd ? rd_head.col : wr_head.col;
        want_data = wr_head.data;                  // arbiter masks it for non-WR
        if (!is_open) begin
            want_cmd = CMD_ACT;
        end else if (row_hit) begin
            want_cmd = head_is_rd ? CMD_RD : CMD_WR;
        end else begin
            want_cmd = CMD_PRE;
            want_row = open_row;                   // row being closed
        end
    end

    // the head request leaves its queue only with its RD or WR
    assign rd_pop = grant && (want_cmd == CMD_RD);
    assign wr_pop = grant && (want_cmd == CMD_WR);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            is_open  <= 1'b0;
            open_row <= '0;
            timer    <= '0;
        end else begin
            if (timer != '0) begin
                timer <= timer - 1'b1;
            end
            if (grant) begin
                case (want_cmd)
                    CMD_ACT: begin
                        is_open  <= 1'b1;
                        open_row <= head_row;
                        timer    <= TMR_W'(`SCHED_ACT_LAT);
                    end
                    CMD_PRE: begin
                        is_open <= 1'b0;
                        timer   <= TMR_W'(`SCHED_PRE_LAT);
                    end
                    default: ;  // rd/wr leave the row open
                endcase
            end
        end
    end

endmodule

// ==== cmd_arbiter.sv ====
`include "sched_consts.svh"

module cmd_arbiter import sched_pkg::*; (
    input  logic                                           clk_in,
    input  logic                                           rst_in,
    input  logic                                           cmd_ready,
    input  logic [`SCHED_NUM_BANKS-1:0]                    want,
    input  dram_cmd_t [`SCHED_NUM_BANKS-1:0]               want_cmd,
    input  logic [`SCHED_NUM_BANKS-1:0][`SCHED_ROW_W-1:0]  want_row,
    input  logic [`SCHED_NUM_BANKS-1:0][`SCHED_COL_W-1:0]  want_col,
    input  logic [`SCHED_NUM_BANKS-1:0][`SCHED_DATA_W-1:0] want_data,
    output logic [`SCHED_NUM_BANKS-1:0]                    grant,
    output logic                                           cmd_valid,
    output dram_cmd_t                                      cmd,
    output logic [`SCHED_BANK_W-1:0]                       cmd_bank,
    output logic [`SCHED_ROW_W-1:0]                        cmd_row,
    output logic [`SCHED_COL_W-1:0]                        cmd_col,
    output logic [`SCHED_DATA_W-1:0]                       cmd_data
);

    localparam int NUM_CLASSES = 3;

    logic                      found;
    logic [`SCHED_BANK_W-1:0]  sel;

    // priority class, lower is served first
    function automatic int cmd_class(input dram_cmd_t c);
        int cls;
        case (c)
            CMD_RD, CMD_WR: cls = 0;
            CMD_ACT:        cls = 1;
            default:        cls = 2;
        endcase
        return cls;
    endfunction

    // fixed priority: class first, then lowest bank index
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            for (int b = 0; b < `SCHED_NUM_BANKS; b++) begin
                if (!found && cmd_ready && want[b] && (cmd_class(want_cmd[b]) == c)) begin
                    found = 1'b1;
                    sel   = `SCHED_BANK_W'(b);
                end
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= found;     // one cycle per grant
        end
    end

    always_ff @(posedge clk_in) begin
        if (found) begin
            cmd      <= want_cmd[sel];
            cmd_bank <= sel;
            cmd_row  <= want_row[sel];
            cmd_col  <= want_col[sel];
            // data only travels with a write
            cmd_data <= (want_cmd[sel] == CMD_WR) ? want_data[sel] : '0;
        end
    end

endmodule

// ==== sched_top.sv ====
`include "sched_consts.svh"

module sched_top import sched_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     req_valid,
    input  logic                     req_write,
    input  logic [`SCHED_ADDR_W-1:0] req_addr,
    input  logic [`SCHED_DATA_W-1:0] req_data,
    input  logic                     cmd_ready,
    output logic                     cmd_valid,
    output dram_cmd_t                cmd,
    output logic [`SCHED_BANK_W-1:0] cmd_bank,
    output logic [`SCHED_ROW_W-1:0]  cmd_row,
    output logic [`SCHED_COL_W-1:0]  cmd_col,
    output logic [`SCHED_DATA_W-1:0] cmd_data
);

    logic [`SCHED_NUM_BANKS-1:0]                    push_rd;
    logic [`SCHED_NUM_BANKS-1:0]                    push_wr;
    rd_req_t                                        rd_req;
    wr_req_t                                        wr_req;

    logic [`SCHED_NUM_BANKS-1:0]                    want;
    dram_cmd_t [`SCHED_NUM_BANKS-1:0]               want_cmd;
    logic [`SCHED_NUM_BANKS-1:0][`SCHED_ROW_W-1:0]  want_row;
    logic [`SCHED_NUM_BANKS-1:0][`SCHED_COL_W-1:0]  want_col;
    logic [`SCHED_NUM_BANKS-1:0][`SCHED_DATA_W-1:0] want_data;
    logic [`SCHED_NUM_BANKS-1:0]                    grant;

    req_router u_router (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .push_rd   (push_rd),
        .push_wr   (push_wr),
        .rd_req    (rd_req),
        .wr_req    (wr_req)
    );

    // one controller per bank, all fed from the shared router payload
    for (genvar i = 0; i < `SCHED_NUM_BANKS; i++) begin : g_bank
        bank_ctrl u_bank (
            .clk_in    (clk_in),
            .rst_in    (rst_in),
            .push_rd   (push_rd[i]),
            .push_wr   (push_wr[i]),
            .rd_req    (rd_req),
            .wr_req    (wr_req),
            .grant     (grant[i]),
            .want      (want[i]),
            .want_cmd  (want_cmd[i]),
            .want_row  (want_row[i]),
            .want_col  (want_col[i]),
            .want_data (want_data[i])
        );
    end

    cmd_arbiter u_arbiter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .cmd_ready (cmd_ready),
        .want      (want),
        .want_cmd  (want_cmd),
        .want_row  (want_row),
        .want_col  (want_col),
        .want_data (want_data),
        .grant     (grant),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_bank  (cmd_bank),
        .cmd_row   (cmd_row),
        .cmd_col   (cmd_col),
        .cmd_data  (cmd_data)
    );

endmodule

// ==== sched_checker.sv ====
`include "sched_consts.svh"

module sched_checker import sched_pkg::*; (
    input logic                     clk_in,
    input logic                     rst_in,
    input logic                     cmd_ready,
    input logic                     cmd_valid,
    input dram_cmd_t                cmd,
    input logic [`SCHED_BANK_W-1:0] cmd_bank,
    input logic [`SCHED_ROW_W-1:0]  cmd_row,
    input logic [`SCHED_COL_W-1:0]  cmd_col,
    input logic [`SCHED_DATA_W-1:0] cmd_data
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_BANKS = `SCHED_NUM_BANKS;
    localparam int MAX_LAT   = (`SCHED_ACT_LAT > `SCHED_PRE_LAT) ? `SCHED_ACT_LAT
                                                                : `SCHED_PRE_LAT;
    localparam int TMR_W     = $clog2(MAX_LAT + 1);

    logic [NUM_BANKS-1:0]     shadow_open;
    logic [`SCHED_ROW_W-1:0]  shadow_row [NUM_BANKS];
    logic [TMR_W-1:0]         recover [NUM_BANKS];  // cycles a bank must stay silent
    logic [`SCHED_DATA_W-1:0] expect_data;

    logic fail_reset    = 1'b0;
    logic fail_ready    = 1'b0;
    logic fail_rowhit   = 1'b0;
    logic fail_state    = 1'b0;
    logic fail_recover  = 1'b0;
    logic fail_wdata    = 1'b0;
    logic any_fail;

    assign any_fail = |{fail_reset, fail_ready, fail_rowhit, fail_state, fail_recover, fail_wdata};

    // write data carries its own address, zero extended
    assign expect_data = `SCHED_DATA_W'({cmd_row, cmd_bank, cmd_col});

    // shadow of each bank, rebuilt from the command outputs only
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            shadow_open <= '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                shadow_row[b] <= '0;
                recover[b]    <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (recover[b] != '0) begin
                    recover[b] <= recover[b] - 1'b1;
                end
            end
            if (cmd_valid && cmd == CMD_ACT) begin
                shadow_open[cmd_bank] <= 1'b1;
                shadow_row[cmd_bank]  <= cmd_row;
                recover[cmd_bank]     <= TMR_W'(`SCHED_ACT_LAT);
            end else if (cmd_valid && cmd == CMD_PRE) begin
                shadow_open[cmd_bank] <= 1'b0;
                recover[cmd_bank]     <= TMR_W'(`SCHED_PRE_LAT);
            end
        end
    end

    reset_quiet: assert property (@(posedge clk_in) (rst_in || $past(rst_in)) |-> !cmd_valid)
        else begin
            $error("[FAIL] %0t cmd_valid got %b expected 0 around reset", $time, cmd_valid);
            fail_reset = 1'b1;
        end

    // a command needs cmd_ready in the cycle it was granted
    ready_before: assert property (@(posedge clk_in) disable iff (rst_in)
        cmd_valid |-> $past(cmd_ready))
        else begin
            $error("[FAIL] %0t cmd_ready got 0 expected 1 before cmd_valid", $time);
            fail_ready = 1'b1;
        end

    rdwr_open_row: assert property (@(posedge clk_in) disable iff (rst_in)
        (cmd_valid && (cmd == CMD_RD || cmd == CMD_WR))
            |-> (shadow_open[cmd_bank] && shadow_row[cmd_bank] == cmd_row))
        else begin
            $error("[FAIL] %0t cmd_row got %h expected %h on bank %0d, open %b", $time,
                   cmd_row, shadow_row[cmd_bank], cmd_bank, shadow_open[cmd_bank]);
            fail_rowhit = 1'b1;
        end

    act_pre_state: assert property (@(posedge clk_in) disable iff (rst_in)
        (cmd_valid && (cmd == CMD_ACT || cmd == CMD_PRE))
            |-> (shadow_open[cmd_bank] == (cmd == CMD_PRE)))
        else begin
            $error("%0t: %s sent to bank %0d while its open state is %b", $time,
                   cmd.name(), cmd_bank, shadow_open[cmd_bank]);
            fail_state = 1'b1;
        end

    bank_recovery: assert property (@(posedge clk_in) disable iff (rst_in)
        cmd_valid |-> (recover[cmd_bank] == '0))
        else begin
            $error("[FAIL] %0t recovery of bank %0d got %0d expected 0", $time,
                   cmd_bank, recover[cmd_bank]);
            fail_recover = 1'b1;
        end

    wr_data_match: assert property (@(posedge clk_in) disable iff (rst_in)
        (cmd_valid && cmd == CMD_WR) |-> (cmd_data == expect_data))
        else begin
            $error("[FAIL] %0t cmd_data got %h expected %h", $time, cmd_data, expect_data);
            fail_wdata = 1'b1;
        end

endmodule

bind sched_top sched_checker u_checker (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .cmd_ready (cmd_ready),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_bank  (cmd_bank),
    .cmd_row   (cmd_row),
    .cmd_col   (cmd_col),
    .cmd_data  (cmd_data)
);

// ==== tb_sched.sv ====
`include "sched_consts.svh"

module tb_sched import sched_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQS    = 200;
    localparam int NUM_BANKS   = `SCHED_NUM_BANKS;
    localparam int ISSUE_LIMIT = 20000;   // cycles allowed to hand out all requests
    localparam int DRAIN_LIMIT = 4000;

    logic                     clk_in = 1'b0;
    logic                     rst_in;
    logic                     req_valid;
    logic                     req_write;
    logic [`SCHED_ADDR_W-1:0] req_addr;
    logic [`SCHED_DATA_W-1:0] req_data;
    logic                     cmd_ready;
    logic                     cmd_valid;
    dram_cmd_t                cmd;
    logic [`SCHED_BANK_W-1:0] cmd_bank;
    logic [`SCHED_ROW_W-1:0]  cmd_row;
    logic [`SCHED_COL_W-1:0]  cmd_col;
    logic [`SCHED_DATA_W-1:0] cmd_data;

    int seed = 61;
    int issued;
    int served;
    int cycles;
    int pending_rd [NUM_BANKS];   // requests not yet seen as RD
    int pending_wr [NUM_BANKS];

    always #4 clk_in = ~clk_in;

    sched_top DUT (.*);

    task automatic fail_run(input string reason);
        $display("TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    // retire an observed RD or WR against its bank's count
    task automatic note_command();
        int b;
        b = int'(cmd_bank);
        if (cmd_valid && cmd == CMD_RD) begin
            if (pending_rd[b] == 0) fail_run("read command on a bank with no read outstanding");
            else begin
                pending_rd[b]--;
                served++;
            end
        end else if (cmd_valid && cmd == CMD_WR) begin
            if (pending_wr[b] == 0) fail_run("write command on a bank with no write outstanding");
            else begin
                pending_wr[b]--;
                served++;
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_in);
        note_command();
        if (DUT.u_checker.any_fail) fail_run("an assertion in the checker failed");
    endtask

    // random ready level and, if allowed and the queue has room, one request
    task automatic drive_cycle(input bit allow_req);
        logic [31:0]               rnd;
        logic [`SCHED_ROW_W-1:0]   row;
        logic [`SCHED_BANK_W-1:0]  bank;
        logic [`SCHED_COL_W-1:0]   col;
        logic [`SCHED_ADDR_W-1:0]  addr;
        logic                      wr;
        bit                        room;
        rnd  = $random(seed);
        row  = `SCHED_ROW_W'(rnd[9:8]);    // four rows per bank give hits and misses
        bank = rnd[3:2];
        col  = rnd[7:4];
        wr   = rnd[10];
        addr = {row, bank, col};
        room = wr ? (pending_wr[bank] < `SCHED_Q_DEPTH) : (pending_rd[bank] < `SCHED_Q_DEPTH);
        cmd_ready <= (rnd[1:0] != 2'b00);
        if (allow_req && rnd[12:11] != 2'b00 && room) begin
            req_valid <= 1'b1;
            req_write <= wr;
            req_addr  <= addr;
            req_data  <= `SCHED_DATA_W'(addr);
            if (wr) pending_wr[bank]++;
            else pending_rd[bank]++;
            issued++;
        end else begin
            req_valid <= 1'b0;
        end
    endtask

    initial begin
        rst_in    = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        cmd_ready = 1'b0;
        issued    = 0;
        served    = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            pending_rd[b] = 0;
            pending_wr[b] = 0;
        end
        repeat (4) @(posedge clk_in);
        rst_in <= 1'b0;

        cycles = 0;
        while (issued < NUM_REQS && cycles < ISSUE_LIMIT) begin
            drive_cycle(1'b1);
            next_cycle();
            cycles++;
        end
        if (issued < NUM_REQS) fail_run("timeout while issuing requests, queues stayed full");

        cycles = 0;
        while (served < issued && cycles < DRAIN_LIMIT) begin
            drive_cycle(1'b0);
            next_cycle();
            cycles++;
        end
        next_cycle();

        if (served == issued && !DUT.u_checker.any_fail) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("timeout, only %0d of %0d requests were served", served, issued));
        end
    end

endmodule

// ==== sources.f ====
+incdir+.
sched_pkg.sv
req_fifo.sv
req_router.sv
bank_ctrl.sv
cmd_arbiter.sv
sched_top.sv
sched_checker.sv
tb_sched.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_sched \
    -f sources.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -qx "TESTS PASSED" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
